// ==== common/pmu_pkg.sv ====
package pmu_pkg;

	// number of switch segments in each generic domain chain
	localparam int SW_STAGES = 3;

	typedef enum logic [2:0] {
		PMU_ACTIVE   = 3'd0,
		PMU_UP_IO    = 3'd1,
		PMU_UP_MRAM  = 3'd2,
		PMU_UP_MEM   = 3'd3,
		PMU_UP_UDMA  = 3'd4,
		PMU_UP_LOGIC = 3'd5,
		PMU_SLEEP    = 3'd6
	} pmu_state_e;

	typedef struct packed {
		logic [27:0] reserved;
		logic        pd_mram;
		logic        pd_l2;
		logic        pd_io;
		logic        retentive;
	} pmu_mode_t;

	// one bit per domain, lgc is the logic domain
	typedef struct packed {
		logic io;
		logic mram;
		logic mem;
		logic udma;
		logic lgc;
	} pd_vec_t;

	typedef struct packed {
		logic        wen;
		logic        pmu_en;
		logic [31:0] scratch;
		pmu_mode_t   mode;
	} pmu_reg_wr_t;

	typedef struct packed {
		logic [31:0] scratch;
		pmu_mode_t   mode;
	} pmu_reg_rd_t;

	typedef struct packed {
		logic [SW_STAGES-1:0] lgc;
		logic [SW_STAGES-1:0] mem;
		logic [SW_STAGES-1:0] io;
		logic [SW_STAGES-1:0] udma;
	} pd_sw_t;

	// active low domain resets
	typedef struct packed {
		logic lgc;
		logic udma;
		logic ram_rom;
	} pd_rstn_t;

	typedef struct packed {
		logic vdd;
		logic vdda;
		logic vref;
		logic porb;
		logic rstb;
		logic retb;
		logic trim;
		logic dpd;
		logic ceb_high;
	} mram_pins_t;

endpackage

// ==== filelist.f ====
common/pmu_pkg.sv
rtl/pmu_regs.sv
rtl/wakeup_timer.sv
pmu/pmu_sequencer.sv
pmu/pd_ctrl.sv
pmu/mram_pg_ctrl.sv
rtl/pmu_top.sv
sim/pmu_checker.sv
sim/tb_pmu.sv

// ==== pmu/mram_pg_ctrl.sv ====
`timescale 1ns/1ps

module mram_pg_ctrl #(
	parameter int MRAM_STEP_CYCLES = 4
) (
	input  logic                clk_i,
	input  logic                rstn_i,
	input  logic                power_i,
	output pmu_pkg::mram_pins_t pins_o,
	output logic                done_o
);

	localparam int DWELL_W = (MRAM_STEP_CYCLES > 1) ? $clog2(MRAM_STEP_CYCLES) : 1;
	localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(MRAM_STEP_CYCLES - 1);
	localparam logic [3:0] STEP_LAST = 4'd9;

	logic [3:0]         step_q;
	logic [DWELL_W-1:0] dwell_q;
	logic               done_q;
	logic [3:0]         target;
	logic               at_target;

	assign target    = power_i ? STEP_LAST : 4'd0;
	assign at_target = (step_q == target);

	// a reversed request walks back from whatever step was reached
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			step_q  <= '0;
			dwell_q <= '0;
			done_q  <= 1'b0;
		end else begin
			if (!at_target)
				done_q <= 1'b0;
			if (at_target && done_q) begin
				dwell_q <= '0;
			end else if (dwell_q == DWELL_LAST) begin
				dwell_q <= '0;
				if (at_target)
					done_q <= 1'b1;
				else if (power_i)
					step_q <= step_q + 4'd1;
				else
					step_q <= step_q - 4'd1;
			end else begin
				dwell_q <= dwell_q + 1'b1;
			end
		end
	end

	// step k has moved the first k pins of the list to their on level
	always_comb begin
		pins_o.dpd      = (step_q < 4'd1);
		pins_o.vdd      = (step_q >= 4'd2);
		pins_o.vdda     = (step_q >= 4'd3);
		pins_o.vref     = (step_q >= 4'd4);
		pins_o.porb     = (step_q >= 4'd5);
		pins_o.rstb     = (step_q >= 4'd6);
		pins_o.retb     = (step_q >= 4'd7);
		pins_o.trim     = (step_q >= 4'd8);
		pins_o.ceb_high = (step_q < STEP_LAST);
	end

	// the last pin also gets a full dwell before done
	assign done_o = done_q && at_target;

endmodule

// ==== pmu/pd_ctrl.sv ====
`timescale 1ns/1ps

module pd_ctrl (
	input  logic                          clk_i,
	input  logic                          rstn_i,
	input  logic                          power_i,
	output logic [pmu_pkg::SW_STAGES-1:0] sw_en_o,
	input  logic [pmu_pkg::SW_STAGES-1:0] sw_ack_i,
	output logic                          iso_o,
	output logic                          rstn_o,
	output logic                          clk_en_o,
	output logic                          done_o
);

	localparam int IDX_W = (pmu_pkg::SW_STAGES > 1) ? $clog2(pmu_pkg::SW_STAGES) : 1;
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(pmu_pkg::SW_STAGES - 1);

	typedef enum logic [2:0] {
		PD_OFF,
		PD_SW_UP,
		PD_ISO_REL,
		PD_CLK_ON,
		PD_ON,
		PD_ISO_SET,
		PD_RST_SET,
		PD_SW_DOWN
	} pd_phase_e;

	pd_phase_e        phase_q;
	logic [IDX_W-1:0] idx_q;

	// reset lands in the down walk so done waits until segment 0 is seen off
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			phase_q  <= PD_SW_DOWN;
			idx_q    <= '0;
			sw_en_o  <= '0;
			iso_o    <= 1'b1;
			rstn_o   <= 1'b0;
			clk_en_o <= 1'b0;
		end else begin
			case (phase_q)
				PD_OFF: begin
					if (power_i) begin
						sw_en_o[0] <= 1'b1;
						idx_q      <= '0;
						phase_q    <= PD_SW_UP;
					end
				end
				PD_SW_UP: begin
					if (!power_i) begin
						sw_en_o[idx_q] <= 1'b0;
						phase_q        <= PD_SW_DOWN;
					end else if (sw_ack_i[idx_q]) begin
						if (idx_q == IDX_LAST) begin
							rstn_o  <= 1'b1;
							phase_q <= PD_ISO_REL;
						end else begin
							sw_en_o[idx_q + 1'b1] <= 1'b1;
							idx_q                 <= idx_q + 1'b1;
						end
					end
				end
				PD_ISO_REL: begin
					iso_o   <= 1'b0;
					phase_q <= PD_CLK_ON;
				end
				PD_CLK_ON: begin
					clk_en_o <= 1'b1;
					phase_q  <= PD_ON;
				end
				PD_ON: begin
					if (!power_i) begin
						clk_en_o <= 1'b0;
						phase_q  <= PD_ISO_SET;
					end
				end
				PD_ISO_SET: begin
					iso_o   <= 1'b1;
					phase_q <= PD_RST_SET;
				end
				PD_RST_SET: begin
					rstn_o            <= 1'b0;
					sw_en_o[IDX_LAST] <= 1'b0;
					idx_q             <= IDX_LAST;
					phase_q           <= PD_SW_DOWN;
				end
				PD_SW_DOWN: begin
					if (power_i) begin
						sw_en_o[idx_q] <= 1'b1;
						phase_q        <= PD_SW_UP;
					end else if (!sw_ack_i[idx_q]) begin
						if (idx_q == '0) begin
							phase_q <= PD_OFF;
						end else begin
							sw_en_o[idx_q - 1'b1] <= 1'b0;
							idx_q                 <= idx_q - 1'b1;
						end
					end
				end
				default: phase_q <= PD_SW_DOWN;
			endcase
		end
	end

	assign done_o = power_i ? (phase_q == PD_ON) : (phase_q == PD_OFF);

	assert property (@(posedge clk_i) disable iff (!rstn_i) clk_en_o |-> !iso_o);

endmodule

// ==== pmu/pmu_sequencer.sv ====
`timescale 1ns/1ps

module pmu_sequencer (
	input  logic               clk_i,
	input  logic               rstn_i,
	input  logic               sleeping_i,
	input  pmu_pkg::pmu_mode_t mode_i,
	input  pmu_pkg::pd_vec_t   done_i,
	output pmu_pkg::pd_vec_t   req_o
);

	pmu_pkg::pmu_state_e state_q;
	pmu_pkg::pmu_state_e state_d;
	pmu_pkg::pd_vec_t    sleep_set;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state_q <= pmu_pkg::PMU_SLEEP;
		end else begin
			state_q <= state_d;
		end
	end

	// wake order is io, mram, mem, udma, logic
	always_comb begin
		state_d = state_q;
		case (state_q)
			pmu_pkg::PMU_SLEEP: begin
				if (!sleeping_i && (&done_i))
					state_d = pmu_pkg::PMU_UP_IO;
			end
			pmu_pkg::PMU_UP_IO: begin
				if (done_i.io)
					state_d = pmu_pkg::PMU_UP_MRAM;
			end
			pmu_pkg::PMU_UP_MRAM: begin
				if (done_i.mram)
					state_d = pmu_pkg::PMU_UP_MEM;
			end
			pmu_pkg::PMU_UP_MEM: begin
				if (done_i.mem)
					state_d = pmu_pkg::PMU_UP_UDMA;
			end
			pmu_pkg::PMU_UP_UDMA: begin
				if (done_i.udma)
					state_d = pmu_pkg::PMU_UP_LOGIC;
			end
			pmu_pkg::PMU_UP_LOGIC: begin
				if (done_i.lgc)
					state_d = pmu_pkg::PMU_ACTIVE;
			end
			pmu_pkg::PMU_ACTIVE: begin
				if (sleeping_i)
					state_d = pmu_pkg::PMU_SLEEP;
			end
			default: state_d = pmu_pkg::PMU_SLEEP;
		endcase
	end

	// retention set kept alive during sleep
	always_comb begin
		sleep_set.io   = mode_i.retentive && !mode_i.pd_io;
		sleep_set.mram = mode_i.retentive && !mode_i.pd_mram;
		sleep_set.mem  = mode_i.retentive && !mode_i.pd_l2;
		sleep_set.udma = sleep_set.mram || sleep_set.mem;
		sleep_set.lgc  = 1'b0;
	end

	// domains not yet reached keep their sleep level
	always_comb begin
		req_o = sleep_set;
		case (state_q)
			pmu_pkg::PMU_ACTIVE: begin
				req_o.io   = 1'b1;
				req_o.mram = !mode_i.pd_mram;
				req_o.mem  = 1'b1;
				req_o.udma = 1'b1;
				req_o.lgc  = 1'b1;
			end
			pmu_pkg::PMU_UP_IO: begin
				req_o.io = 1'b1;
			end
			pmu_pkg::PMU_UP_MRAM: begin
				req_o.io   = 1'b1;
				req_o.mram = 1'b1;
			end
			pmu_pkg::PMU_UP_MEM: begin
				req_o.io   = 1'b1;
				req_o.mram = 1'b1;
				req_o.mem  = 1'b1;
			end
			pmu_pkg::PMU_UP_UDMA: begin
				req_o.io   = 1'b1;
				req_o.mram = 1'b1;
				req_o.mem  = 1'b1;
				req_o.udma = 1'b1;
			end
			pmu_pkg::PMU_UP_LOGIC: begin
				req_o.io   = 1'b1;
				req_o.mram = 1'b1;
				req_o.mem  = 1'b1;
				req_o.udma = 1'b1;
				req_o.lgc  = 1'b1;
			end
			default: begin
				req_o = sleep_set;
			end
		endcase
	end

	// logic must never be powered before the io ring is up
	assert property (@(posedge clk_i) disable iff (!rstn_i) req_o.lgc |-> done_i.io);

endmodule

// ==== rtl/pmu_regs.sv ====
`timescale 1ns/1ps

module pmu_regs (
	input  logic                 clk_i,
	input  logic                 rstn_i,
	input  pmu_pkg::pmu_reg_wr_t reg_wr_i,
	input  logic                 wakeup_i,
	output pmu_pkg::pmu_reg_rd_t reg_rd_o,
	output logic                 sleeping_o
);

	// scratch and mode registers, read back directly
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			reg_rd_o <= '0;
		end else if (reg_wr_i.wen) begin
			reg_rd_o.scratch <= reg_wr_i.scratch;
			reg_rd_o.mode    <= reg_wr_i.mode;
		end
	end

	// awake until a write carries pmu_en, asleep until the timer fires
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			sleeping_o <= 1'b0;
		end else if (!sleeping_o) begin
			sleeping_o <= reg_wr_i.wen && reg_wr_i.pmu_en;
		end else if (wakeup_i) begin
			sleeping_o <= 1'b0;
		end
	end

	// sleep only ever starts from a software write
	assert property (@(posedge clk_i) disable iff (!rstn_i)
		$rose(sleeping_o) |-> $past(reg_wr_i.wen && reg_wr_i.pmu_en));

endmodule

// ==== rtl/pmu_top.sv ====
`timescale 1ns/1ps

module pmu_top #(
	parameter int TICK_CYCLES      = 32,
	parameter int MRAM_STEP_CYCLES = 4
) (
	input  logic                 clk_i,
	input  logic                 rstn_i,
	input  pmu_pkg::pmu_reg_wr_t reg_wr_i,
	output pmu_pkg::pmu_reg_rd_t reg_rd_o,
	output logic                 pg_rstn_o,
	output pmu_pkg::pd_sw_t      sw_en_o,
	input  pmu_pkg::pd_sw_t      sw_ack_i,
	output pmu_pkg::pd_rstn_t    pd_rstn_o,
	output pmu_pkg::pd_vec_t     pd_iso_o,
	output pmu_pkg::pd_vec_t     pd_clk_en_o,
	output pmu_pkg::mram_pins_t  mram_o
);

	logic             sleeping;
	logic             wakeup;
	pmu_pkg::pd_vec_t req;
	pmu_pkg::pd_vec_t done;

	assign pg_rstn_o        = !sleeping;
	assign pd_iso_o.mram    = 1'b0;
	assign pd_clk_en_o.mram = done.mram;

	pmu_regs u_regs (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.reg_wr_i   (reg_wr_i),
		.wakeup_i   (wakeup),
		.reg_rd_o   (reg_rd_o),
		.sleeping_o (sleeping)
	);

	wakeup_timer #(.TICK_CYCLES(TICK_CYCLES)) u_timer (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.sleeping_i (sleeping),
		.scratch_i  (reg_rd_o.scratch),
		.wakeup_o   (wakeup)
	);

	pmu_sequencer u_seq (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.sleeping_i (sleeping),
		.mode_i     (reg_rd_o.mode),
		.done_i     (done),
		.req_o      (req)
	);

	pd_ctrl u_pd_logic (
		.clk_i (clk_i), .rstn_i (rstn_i), .power_i (req.lgc),
		.sw_en_o (sw_en_o.lgc), .sw_ack_i (sw_ack_i.lgc),
		.iso_o (pd_iso_o.lgc), .rstn_o (pd_rstn_o.lgc),
		.clk_en_o (pd_clk_en_o.lgc), .done_o (done.lgc)
	);

	pd_ctrl u_pd_mem (
		.clk_i (clk_i), .rstn_i (rstn_i), .power_i (req.mem),
		.sw_en_o (sw_en_o.mem), .sw_ack_i (sw_ack_i.mem),
		.iso_o (pd_iso_o.mem), .rstn_o (pd_rstn_o.ram_rom),
		.clk_en_o (pd_clk_en_o.mem), .done_o (done.mem)
	);

	// io ring reset stays unconnected
	pd_ctrl u_pd_io (
		.clk_i (clk_i), .rstn_i (rstn_i), .power_i (req.io),
		.sw_en_o (sw_en_o.io), .sw_ack_i (sw_ack_i.io),
		.iso_o (pd_iso_o.io), .rstn_o (),
		.clk_en_o (pd_clk_en_o.io), .done_o (done.io)
	);

	pd_ctrl u_pd_udma (
		.clk_i (clk_i), .rstn_i (rstn_i), .power_i (req.udma),
		.sw_en_o (sw_en_o.udma), .sw_ack_i (sw_ack_i.udma),
		.iso_o (pd_iso_o.udma), .rstn_o (pd_rstn_o.udma),
		.clk_en_o (pd_clk_en_o.udma), .done_o (done.udma)
	);

	mram_pg_ctrl #(.MRAM_STEP_CYCLES(MRAM_STEP_CYCLES)) u_pd_mram (
		.clk_i   (clk_i),
		.rstn_i  (rstn_i),
		.power_i (req.mram),
		.pins_o  (mram_o),
		.done_o  (done.mram)
	);

endmodule

// ==== rtl/wakeup_timer.sv ====
`timescale 1ns/1ps

module wakeup_timer #(
	parameter int TICK_CYCLES = 32
) (
	input  logic        clk_i,
	input  logic        rstn_i,
	input  logic        sleeping_i,
	input  logic [31:0] scratch_i,
	output logic        wakeup_o
);

	localparam int PRE_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICK_CYCLES - 1);

	logic [PRE_W-1:0] pre_q;
	logic [31:0]      tick_cnt_q;
	logic             tick;

	assign tick = (pre_q == PRE_LAST);

	// prescaler only runs during sleep
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			pre_q <= '0;
		end else if (!sleeping_i || tick) begin
			pre_q <= '0;
		end else begin
			pre_q <= pre_q + 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			tick_cnt_q <= '0;
		end else if (!sleeping_i) begin
			tick_cnt_q <= '0;
		end else if (tick) begin
			tick_cnt_q <= tick_cnt_q + 32'd1;
		end
	end

	assign wakeup_o = (tick_cnt_q >= scratch_i);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the PMU testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_pmu -Mdir obj_dir -o sim_pmu
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_pmu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sim/pmu_checker.sv ====
`timescale 1ns/1ps

module pmu_checker #(
	parameter int TICK_CYCLES   = 32,
	parameter int SETTLE_CYCLES = 48
) (
	input  logic                 clk_i,
	input  logic                 rstn_i,
	input  pmu_pkg::pmu_reg_wr_t reg_wr_i,
	input  pmu_pkg::pmu_reg_rd_t reg_rd_i,
	input  logic                 pg_rstn_i,
	input  pmu_pkg::pd_sw_t      sw_en_i,
	input  pmu_pkg::pd_sw_t      sw_ack_i,
	input  pmu_pkg::pd_rstn_t    pd_rstn_i,
	input  pmu_pkg::pd_vec_t     pd_iso_i,
	input  pmu_pkg::pd_vec_t     pd_clk_en_i,
	input  pmu_pkg::mram_pins_t  mram_i,
	input  pmu_pkg::pd_vec_t     exp_sleep_i,
	output int                   err_cnt_o,
	output int                   chk_cnt_o
);

	int                   errors = 0;
	int                   checks = 0;
	int                   stage;
	int                   low_cnt;
	int                   len_min;
	int                   len_max;
	bit                   rd_pending;
	pmu_pkg::pmu_reg_rd_t rd_exp;
	logic [31:0]          sleep_scratch;
	logic [4:0]           wake_lvl;
	logic [4:0]           wake_lvl_q;
	logic [8:0]           mram_on;
	logic [12:0]          ret_exp;

	assign err_cnt_o = errors;
	assign chk_cnt_o = checks;

	// wake events in order: io, mram, mem, udma, logic clock
	assign wake_lvl = {pd_clk_en_i.lgc, &sw_en_i.udma, &sw_en_i.mem,
		!mram_i.ceb_high && pd_clk_en_i.mram, &sw_en_i.io};

	// mram pins at their on level, in list order
	assign mram_on = {!mram_i.ceb_high, mram_i.trim, mram_i.retb, mram_i.rstb,
		mram_i.porb, mram_i.vref, mram_i.vdda, mram_i.vdd, !mram_i.dpd};

	function automatic string wake_name(input int k);
		case (k)
			0: return "io";
			1: return "mram";
			2: return "mem";
			3: return "udma";
			default: return "logic";
		endcase
	endfunction

	task automatic log_error(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic check_domain(input string name, input logic clk_en, input logic iso,
		input logic rst_rel, input logic [pmu_pkg::SW_STAGES-1:0] ack);
		if (clk_en && iso)
			log_error($sformatf("%s domain clock enabled while isolated", name));
		if (!iso && !(rst_rel && (&ack)))
			log_error($sformatf("%s domain isolation released before reset and power", name));
	endtask

	// sample between edges where DUT outputs and driven inputs are settled
	always @(negedge clk_i) begin
		if (!rstn_i) begin
			stage      = 0;
			low_cnt    = 0;
			rd_pending = 1'b0;
			wake_lvl_q = '0;
		end else begin
			if (rd_pending) begin
				checks++;
				if (reg_rd_i !== rd_exp)
					log_error($sformatf("Mismatch readback expected %h actual %h",
						rd_exp, reg_rd_i));
			end
			rd_pending = reg_wr_i.wen;
			rd_exp     = {reg_wr_i.scratch, reg_wr_i.mode};
			if (reg_wr_i.wen && reg_wr_i.pmu_en && pg_rstn_i)
				sleep_scratch = reg_wr_i.scratch;

			if (!pg_rstn_i) begin
				low_cnt++;
				stage = 0;
			end else if (low_cnt != 0) begin
				len_min = (sleep_scratch == 0) ? 1 : sleep_scratch * TICK_CYCLES;
				len_max = (sleep_scratch == 0) ? 2 : sleep_scratch * TICK_CYCLES + TICK_CYCLES + 2;
				checks++;
				if (low_cnt < len_min || low_cnt > len_max)
					log_error($sformatf("Mismatch sleep_length expected %0d..%0d actual %0d",
						len_min, len_max, low_cnt));
				// domains only reach their sleep levels on longer sleeps
				if (low_cnt >= SETTLE_CYCLES) begin
					ret_exp = {{3{exp_sleep_i.lgc}}, {3{exp_sleep_i.mem}}, {3{exp_sleep_i.io}},
						{3{exp_sleep_i.udma}}, exp_sleep_i.mram};
					checks++;
					if ({sw_en_i, mram_i.vdd} !== ret_exp)
						log_error($sformatf("Mismatch sleep_retention expected %h actual %h",
							ret_exp, {sw_en_i, mram_i.vdd}));
				end
				low_cnt = 0;
			end

			if (pg_rstn_i && stage < 5) begin
				for (int j = stage + 1; j < 5; j++) begin
					if (wake_lvl[j] && !wake_lvl_q[j])
						log_error($sformatf("wake order broken, %s came up before %s",
							wake_name(j), wake_name(stage)));
				end
				while (stage < 5 && wake_lvl[stage])
					stage++;
				if (stage == 5)
					checks++;
			end
			wake_lvl_q = wake_lvl;

			check_domain("logic", pd_clk_en_i.lgc, pd_iso_i.lgc, pd_rstn_i.lgc, sw_ack_i.lgc);
			check_domain("mem", pd_clk_en_i.mem, pd_iso_i.mem, pd_rstn_i.ram_rom, sw_ack_i.mem);
			check_domain("io", pd_clk_en_i.io, pd_iso_i.io, 1'b1, sw_ack_i.io);
			check_domain("udma", pd_clk_en_i.udma, pd_iso_i.udma, pd_rstn_i.udma, sw_ack_i.udma);
			if (pd_iso_i.mram !== 1'b0)
				log_error("mram isolation output is not held low");
			if (((mram_on + 9'd1) & mram_on) != 9'd0)
				log_error($sformatf("mram pins out of sequence, on levels %b", mram_on));
		end
	end

endmodule

// ==== sim/tb_pmu.sv ====
`timescale 1ns/1ps

module tb_pmu;

	localparam int TICK_CYCLES      = 8;
	localparam int MRAM_STEP_CYCLES = 2;
	localparam int N_SLEEPS         = 20;
	localparam int MAX_SCRATCH      = 20;
	localparam int WAKE_PERIOD      = MAX_SCRATCH * TICK_CYCLES + TICK_CYCLES + 2;
	localparam int TIMEOUT_CYCLES   = 40 * WAKE_PERIOD + 2000;

	logic                 clk;
	logic                 rstn;
	pmu_pkg::pmu_reg_wr_t reg_wr;
	pmu_pkg::pmu_reg_rd_t reg_rd;
	logic                 pg_rstn;
	pmu_pkg::pd_sw_t      sw_en;
	pmu_pkg::pd_sw_t      sw_ack;
	pmu_pkg::pd_rstn_t    pd_rstn;
	pmu_pkg::pd_vec_t     pd_iso;
	pmu_pkg::pd_vec_t     pd_clk_en;
	pmu_pkg::mram_pins_t  mram;
	pmu_pkg::pd_vec_t     exp_sleep;
	pmu_pkg::pmu_mode_t   mode;
	logic [31:0]          scratch;
	int                   err_cnt;
	int                   chk_cnt;
	int                   ack_wait [12];
	integer               seed;
	integer               ack_seed;

	pmu_top #(.TICK_CYCLES(TICK_CYCLES), .MRAM_STEP_CYCLES(MRAM_STEP_CYCLES)) DUT (
		.clk_i (clk), .rstn_i (rstn), .reg_wr_i (reg_wr), .reg_rd_o (reg_rd),
		.pg_rstn_o (pg_rstn), .sw_en_o (sw_en), .sw_ack_i (sw_ack), .pd_rstn_o (pd_rstn),
		.pd_iso_o (pd_iso), .pd_clk_en_o (pd_clk_en), .mram_o (mram)
	);

	pmu_checker #(.TICK_CYCLES(TICK_CYCLES)) u_checker (
		.clk_i (clk), .rstn_i (rstn), .reg_wr_i (reg_wr), .reg_rd_i (reg_rd),
		.pg_rstn_i (pg_rstn), .sw_en_i (sw_en), .sw_ack_i (sw_ack), .pd_rstn_i (pd_rstn),
		.pd_iso_i (pd_iso), .pd_clk_en_i (pd_clk_en), .mram_i (mram),
		.exp_sleep_i (exp_sleep), .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
	);

	// domains that stay powered through sleep for a given mode word
	function automatic pmu_pkg::pd_vec_t expected_sleep_set(input pmu_pkg::pmu_mode_t m);
		pmu_pkg::pd_vec_t s;
		s = '0;
		if (m.retentive) begin
			s.io   = !m.pd_io;
			s.mram = !m.pd_mram;
			s.mem  = !m.pd_l2;
		end
		s.udma = s.mram | s.mem;
		return s;
	endfunction

	task automatic write_regs(input logic sleep_en, input logic [31:0] scr,
		input pmu_pkg::pmu_mode_t m);
		@(posedge clk);
		reg_wr.wen     <= 1'b1;
		reg_wr.pmu_en  <= sleep_en;
		reg_wr.scratch <= scr;
		reg_wr.mode    <= m;
		exp_sleep      <= expected_sleep_set(m);
		@(posedge clk);
		reg_wr.wen    <= 1'b0;
		reg_wr.pmu_en <= 1'b0;
	endtask

	// logic clock always drops in sleep, so wait for it to fall and come back
	task automatic wait_wake_done;
		do @(negedge clk); while (pd_clk_en.lgc !== 1'b0);
		do @(negedge clk); while (pd_clk_en.lgc !== 1'b1);
		repeat (3) @(posedge clk);
	endtask

	task automatic finish_run(input bit timed_out);
		$display("Checks %0d, errors %0d, timeout %0d", chk_cnt, err_cnt, timed_out);
		if (!timed_out && err_cnt == 0 && chk_cnt > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// switch segment model, each ack follows its enable after 1 to 4 cycles
	always @(posedge clk) begin
		for (int i = 0; i < 12; i++) begin
			if (sw_ack[i] == sw_en[i]) begin
				ack_wait[i] = -1;
			end else begin
				if (ack_wait[i] < 0)
					ack_wait[i] = $unsigned($random(ack_seed)) % 4;
				if (ack_wait[i] == 0)
					sw_ack[i] <= sw_en[i];
				else
					ack_wait[i] = ack_wait[i] - 1;
			end
		end
	end

	initial begin
		seed      = 32'he92abb61;
		ack_seed  = seed ^ 32'h3c3c3c3c;
		rstn      = 1'b0;
		reg_wr    = '0;
		sw_ack    = '0;
		exp_sleep = '0;
		foreach (ack_wait[i])
			ack_wait[i] = -1;
		repeat (8) @(posedge clk);
		rstn <= 1'b1;
		wait_wake_done();
		repeat (3) begin
			write_regs(1'b0, $random(seed), $random(seed));
			repeat (2) @(posedge clk);
		end
		for (int n = 0; n < N_SLEEPS; n++) begin
			if (n == 0)
				scratch = 0;
			else if (n == 1)
				scratch = MAX_SCRATCH;
			else
				scratch = $unsigned($random(seed)) % (MAX_SCRATCH + 1);
			mode = $random(seed);
			write_regs(1'b1, scratch, mode);
			wait_wake_done();
		end
		finish_run(1'b0);
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout, the power sequences did not finish within %0d cycles", TIMEOUT_CYCLES);
		finish_run(1'b1);
	end

endmodule
